// File: source/vic_pkg.sv
`default_nettype none

package vic_pkg;

    // sprite count used when the top level is not overridden
    parameter int num_sprites_default = 8;

    // clk_dot4x cycles in one phi phase
    parameter int phase_clocks = 4;

    // two phases per cycle, 63 cycles per raster line
    parameter int line_phases = 126;

    // character columns fetched on a badline
    parameter int char_cols = 40;

    // cycle type of one phi phase
    typedef enum logic [3:0] {
        // sprite pointer fetch
        VIC_LP  = 4'd0,
        // sprite data fetches, one byte each
        VIC_HS1 = 4'd1,
        VIC_LS2 = 4'd2,
        VIC_HS3 = 4'd3,
        // badline character fetch
        VIC_HRC = 4'd4,
        // character replayed from the line cache
        VIC_HRX = 4'd5,
        // graphics fetch
        VIC_LG  = 4'd6,
        // nothing fetched
        VIC_LI  = 4'd7
    } cycle_type_t;

    // 12-bit data bus word, color nibble over character code
    typedef struct packed {
        logic [3:0] color;
        logic [7:0] code;
    } char_word_t;

    // one fetch slot per phi phase
    typedef struct packed {
        // single-clock pulse at phase start
        logic        strobe;
        cycle_type_t ctype;
        // sprite number for LP and HS/LS phases
        logic [2:0]  sprite_idx;
    } fetch_slot_t;

endpackage

`default_nettype wire

// File: source/cycle_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer #(
    parameter int num_sprites = vic_pkg::num_sprites_default
) (
    input  wire                 rst,
    input  wire                 clk_dot4x,
    input  wire                 badline,
    output vic_pkg::fetch_slot_t slot
);

    import vic_pkg::*;

    localparam int cnt_w = $clog2(phase_clocks);
    localparam int idx_w = $clog2(line_phases);

    // four phases per sprite: LP, HS1, LS2, HS3
    localparam int sprite_phases = num_sprites * 4;
    // character region ends after one c/g pair per column
    localparam int char_end = sprite_phases + 2 * char_cols;

    logic [cnt_w-1:0] phase_cnt;
    logic             phase_last;
    logic [idx_w-1:0] line_phase;
    logic [idx_w-1:0] char_off;
    cycle_type_t      next_ctype;
    logic [2:0]       next_sprite;

    assign phase_last = (phase_cnt == cnt_w'(phase_clocks - 1));

    // dot clock divider
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase_cnt <= '0;
        end else if (phase_last) begin
            phase_cnt <= '0;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    // phase index within the raster line
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            line_phase <= '0;
        end else if (phase_last) begin
            if (line_phase == idx_w'(line_phases - 1)) begin
                line_phase <= '0;
            end else begin
                line_phase <= line_phase + 1'b1;
            end
        end
    end

    // position inside the character region, even = c-access
    assign char_off = line_phase - idx_w'(sprite_phases);

    // line schedule decode
    always_comb begin
        next_ctype  = VIC_LI;
        next_sprite = '0;
        if (int'(line_phase) < sprite_phases) begin
            next_sprite = 3'(line_phase >> 2);
            case (line_phase[1:0])
                2'd0:    next_ctype = VIC_LP;
                2'd1:    next_ctype = VIC_HS1;
                2'd2:    next_ctype = VIC_LS2;
                default: next_ctype = VIC_HS3;
            endcase
        end else if (int'(line_phase) < char_end) begin
            if (!char_off[0]) begin
                next_ctype = badline ? VIC_HRC : VIC_HRX;
            end else begin
                next_ctype = VIC_LG;
            end
        end
    end

    // registered slot, strobe high for exactly one clock per phase
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            slot.strobe     <= 1'b0;
            slot.ctype      <= VIC_LI;
            slot.sprite_idx <= '0;
        end else begin
            slot.strobe <= phase_last;
            // type and sprite hold between strobes
            if (phase_last) begin
                slot.ctype      <= next_ctype;
                slot.sprite_idx <= next_sprite;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/bus_access.sv
`timescale 1ns/1ps
`default_nettype none

module bus_access #(
    parameter int num_sprites = vic_pkg::num_sprites_default
) (
    input  wire                  rst,
    input  wire                  clk_dot4x,
    input  wire                  vic_write_db,
    input  vic_pkg::fetch_slot_t slot,
    input  vic_pkg::char_word_t  dbi,
    input  wire                  idle,
    input  wire [num_sprites-1:0] sprite_dma,
    output logic [7:0]           sprite_ptr [num_sprites],
    output logic [7:0]           pixels_read,
    output vic_pkg::char_word_t  char_read,
    output vic_pkg::char_word_t  char_next,
    output logic [23:0]          sprite_pixels [num_sprites]
);

    import vic_pkg::*;

    localparam int cache_depth = char_cols - 1;

    // cache plus char_next hold one full line of characters
    char_word_t char_buf [cache_depth];

    logic capture;
    logic c_access;

    // chip driving the bus blocks every capture
    assign capture  = slot.strobe && !vic_write_db;
    assign c_access = (slot.ctype == VIC_HRC) || (slot.ctype == VIC_HRX);

    // c-access and character line cache
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            char_next <= '0;
            for (int i = 0; i < cache_depth; i++) begin
                char_buf[i] <= 12'h0ff;
            end
        end else if (capture && c_access) begin
            if (slot.ctype == VIC_HRC) begin
                char_next <= dbi;
            end else begin
                // replay from the previous badline
                char_next <= char_buf[cache_depth-1];
            end
            for (int i = cache_depth - 1; i > 0; i--) begin
                char_buf[i] <= char_buf[i-1];
            end
            char_buf[0] <= char_next;
        end
    end

    // g-access
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixels_read <= '0;
            char_read   <= '0;
        end else if (capture) begin
            if (slot.ctype == VIC_LG) begin
                pixels_read <= dbi.code;
                char_read   <= idle ? char_word_t'('0) : char_next;
            end else begin
                // pixel byte lives for one phase only
                pixels_read <= '0;
            end
        end
    end

    // p-access
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int i = 0; i < num_sprites; i++) begin
                sprite_ptr[i] <= '0;
            end
        end else if (capture && slot.ctype == VIC_LP) begin
            if (sprite_dma[slot.sprite_idx]) begin
                sprite_ptr[slot.sprite_idx] <= dbi.code;
            end else begin
                sprite_ptr[slot.sprite_idx] <= 8'hff;
            end
        end
    end

    // s-access, three bytes shifted in msb first
    always_ff @(posedge clk_dot4x) begin
        if (capture && sprite_dma[slot.sprite_idx]) begin
            case (slot.ctype)
                VIC_HS1, VIC_LS2, VIC_HS3: begin
                    sprite_pixels[slot.sprite_idx] <=
                        {sprite_pixels[slot.sprite_idx][15:0], dbi.code};
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/vic_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module vic_fetch_top #(
    parameter int num_sprites = vic_pkg::num_sprites_default
) (
    input  wire                    rst,
    input  wire                    clk_dot4x,
    input  vic_pkg::char_word_t    dbi,
    input  wire                    vic_write_db,
    // held for a whole raster line
    input  wire                    badline,
    input  wire                    idle,
    input  wire [num_sprites-1:0]  sprite_dma,
    // lets the environment line up its bus data
    output vic_pkg::fetch_slot_t   slot,
    output logic [7:0]             sprite_ptr [num_sprites],
    output logic [23:0]            sprite_pixels [num_sprites],
    output logic [7:0]             pixels_read,
    output vic_pkg::char_word_t    char_read,
    output vic_pkg::char_word_t    char_next
);

    cycle_sequencer #(
        .num_sprites (num_sprites)
    ) u_sequencer (
        .rst       (rst),
        .clk_dot4x (clk_dot4x),
        .badline   (badline),
        .slot      (slot)
    );

    bus_access #(
        .num_sprites (num_sprites)
    ) u_bus_access (
        .rst           (rst),
        .clk_dot4x     (clk_dot4x),
        .vic_write_db  (vic_write_db),
        .slot          (slot),
        .dbi           (dbi),
        .idle          (idle),
        .sprite_dma    (sprite_dma),
        .sprite_ptr    (sprite_ptr),
        .pixels_read   (pixels_read),
        .char_read     (char_read),
        .char_next     (char_next),
        .sprite_pixels (sprite_pixels)
    );

endmodule

`default_nettype wire

// File: dv/vic_fetch_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module vic_fetch_assertions (
    input wire                  rst,
    input wire                  clk_dot4x,
    input wire                  vic_write_db,
    input vic_pkg::fetch_slot_t slot,
    input wire [7:0]            pixels_read,
    input vic_pkg::char_word_t  char_read,
    input vic_pkg::char_word_t  char_next
);

    import vic_pkg::*;

    // number of failed assertions so far
    int unsigned fail_count = 0;

    // phase strobe is a one-clock pulse
    strobe_single: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        slot.strobe |=> !slot.strobe
    ) else begin
        fail_count++;
        $error("phase strobe high on two consecutive clocks");
    end

    // pixel byte only lives through a graphics phase
    pixels_clear: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        (slot.strobe && !vic_write_db && slot.ctype != VIC_LG) |=> (pixels_read == 8'h00)
    ) else begin
        fail_count++;
        $error("pixels_read not cleared after a non-graphics phase");
    end

    reset_state: assert property (
        @(posedge clk_dot4x)
        rst |=> (pixels_read == 8'h00 && char_read == '0 && char_next == '0 && !slot.strobe)
    ) else begin
        fail_count++;
        $error("outputs not at reset values the clock after reset");
    end

endmodule

bind bus_access vic_fetch_assertions u_assertions (
    .rst          (rst),
    .clk_dot4x    (clk_dot4x),
    .vic_write_db (vic_write_db),
    .slot         (slot),
    .pixels_read  (pixels_read),
    .char_read    (char_read),
    .char_next    (char_next)
);

`default_nettype wire

// File: dv/tb_vic_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vic_fetch;

    import vic_pkg::*;

    localparam int num_sprites   = num_sprites_default;
    localparam int num_rows      = 9;
    localparam int cache_depth   = char_cols - 1;
    localparam int timeout_limit = num_rows * line_phases * phase_clocks + 100;

    // one raster line of stimulus
    typedef struct packed {
        logic       badline;
        logic       idle;
        logic [7:0] dma;
        logic       wr_en;
        logic [6:0] wr_phase;
    } row_t;

    logic                   clk_dot4x;
    logic                   rst;
    char_word_t             dbi;
    logic                   vic_write_db;
    logic                   badline;
    logic                   idle;
    logic [num_sprites-1:0] sprite_dma;
    fetch_slot_t            slot;
    logic [7:0]             sprite_ptr [num_sprites];
    logic [23:0]            sprite_pixels [num_sprites];
    logic [7:0]             pixels_read;
    char_word_t             char_read;
    char_word_t             char_next;

    // reference model state
    char_word_t  m_next;
    char_word_t  m_read;
    char_word_t  m_cache [cache_depth];
    logic [7:0]  m_pixels;
    logic [7:0]  m_ptr [num_sprites];
    logic [23:0] m_spr [num_sprites];
    int          m_spr_bytes [num_sprites];

    logic [31:0] lfsr_state = 32'hf1f511ac;
    int          errors = 0;
    int          cycles = 0;
    string       cur_name = "reset";

    string row_name [num_rows] = '{
        "blank_line", "badline_a", "replay_a", "idle_replay", "badline_b_wr",
        "replay_b_wr", "sprite_wr", "badline_idle", "replay_c"
    };

    // badline, idle, dma mask, write enable, write phase
    row_t rows [num_rows] = '{
        '{1'b0, 1'b0, 8'h00, 1'b0, 7'd0},
        '{1'b1, 1'b0, 8'hff, 1'b0, 7'd0},
        '{1'b0, 1'b0, 8'ha5, 1'b0, 7'd0},
        '{1'b0, 1'b1, 8'h5a, 1'b0, 7'd0},
        '{1'b1, 1'b0, 8'hff, 1'b1, 7'd40},
        '{1'b0, 1'b0, 8'h0f, 1'b1, 7'd57},
        '{1'b0, 1'b0, 8'hff, 1'b1, 7'd6},
        '{1'b1, 1'b1, 8'hf0, 1'b1, 7'd1},
        '{1'b0, 1'b0, 8'h81, 1'b0, 7'd0}
    };

    vic_fetch_top #(
        .num_sprites (num_sprites)
    ) UUT (
        .rst           (rst),
        .clk_dot4x     (clk_dot4x),
        .dbi           (dbi),
        .vic_write_db  (vic_write_db),
        .badline       (badline),
        .idle          (idle),
        .sprite_dma    (sprite_dma),
        .slot          (slot),
        .sprite_ptr    (sprite_ptr),
        .sprite_pixels (sprite_pixels),
        .pixels_read   (pixels_read),
        .char_read     (char_read),
        .char_next     (char_next)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #2 clk_dot4x = ~clk_dot4x;
    end

    // run limit
    always @(posedge clk_dot4x) begin
        cycles++;
        if (cycles >= timeout_limit) begin
            $display("timeout, run did not finish within %0d clocks", timeout_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_word(input string what, input char_word_t exp, input char_word_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_sprite(input string what, input logic [23:0] exp,
                                input logic [23:0] act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_ctype(input string what, input cycle_type_t exp,
                               input cycle_type_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %s actual %s", cur_name, what,
                     exp.name(), act.name());
        end
    endtask

    // line schedule: sprite region, c/g pairs, then idle
    function automatic cycle_type_t expected_ctype(input int p, input logic bl);
        int sprite_end;
        int char_end;
        sprite_end = num_sprites * 4;
        char_end   = sprite_end + 2 * char_cols;
        if (p < sprite_end) begin
            case (p % 4)
                0: return VIC_LP;
                1: return VIC_HS1;
                2: return VIC_LS2;
                default: return VIC_HS3;
            endcase
        end
        if (p < char_end) begin
            if ((p - sprite_end) % 2 == 0) begin
                return bl ? VIC_HRC : VIC_HRX;
            end
            return VIC_LG;
        end
        return VIC_LI;
    endfunction

    task automatic model_reset();
        m_next   = '0;
        m_read   = '0;
        m_pixels = '0;
        for (int i = 0; i < cache_depth; i++) begin
            m_cache[i] = 12'h0ff;
        end
        for (int i = 0; i < num_sprites; i++) begin
            m_ptr[i]       = '0;
            m_spr[i]       = '0;
            m_spr_bytes[i] = 0;
        end
    endtask

    // one accepted capture
    task automatic model_capture(input cycle_type_t ct, input int idx, input char_word_t d,
                                 input logic idl, input logic [7:0] dma);
        char_word_t fetched;
        m_pixels = 8'h00;
        case (ct)
            VIC_LP: begin
                m_ptr[idx] = dma[idx] ? d.code : 8'hff;
            end
            VIC_HS1, VIC_LS2, VIC_HS3: begin
                if (dma[idx]) begin
                    m_spr[idx] = {m_spr[idx][15:0], d.code};
                    if (m_spr_bytes[idx] < 3) begin
                        m_spr_bytes[idx]++;
                    end
                end
            end
            VIC_HRC, VIC_HRX: begin
                fetched = (ct == VIC_HRC) ? d : m_cache[cache_depth-1];
                for (int i = cache_depth - 1; i > 0; i--) begin
                    m_cache[i] = m_cache[i-1];
                end
                m_cache[0] = m_next;
                m_next     = fetched;
            end
            VIC_LG: begin
                m_pixels = d.code;
                m_read   = idl ? char_word_t'(12'h000) : m_next;
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_outputs();
        check_word("char_next", m_next, char_next);
        check_word("char_read", m_read, char_read);
        check_byte("pixels_read", m_pixels, pixels_read);
        for (int i = 0; i < num_sprites; i++) begin
            check_byte($sformatf("sprite_ptr[%0d]", i), m_ptr[i], sprite_ptr[i]);
            // sprite registers have no reset, compare once three bytes are in
            if (m_spr_bytes[i] >= 3) begin
                check_sprite($sformatf("sprite_pixels[%0d]", i), m_spr[i], sprite_pixels[i]);
            end
        end
    endtask

    // returns at the falling edge inside a strobe clock
    task automatic wait_strobe();
        int waited;
        waited = 0;
        @(negedge clk_dot4x);
        while (!slot.strobe && waited < 2 * phase_clocks) begin
            @(negedge clk_dot4x);
            waited++;
        end
        if (!slot.strobe) begin
            errors++;
            $display("no phase strobe seen within %0d clocks in test %s",
                     2 * phase_clocks, cur_name);
        end
    endtask

    initial begin
        cycle_type_t ct;
        logic [31:0] bits;
        logic        wr;
        int          assert_fails;
        rst          = 1'b1;
        dbi          = '0;
        vic_write_db = 1'b0;
        badline      = 1'b0;
        idle         = 1'b0;
        sprite_dma   = '0;
        model_reset();
        repeat (4) @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        rst = 1'b0;
        check_outputs();
        for (int r = 0; r < num_rows; r++) begin
            cur_name   = row_name[r];
            badline    = rows[r].badline;
            idle       = rows[r].idle;
            sprite_dma = rows[r].dma[num_sprites-1:0];
            for (int p = 0; p < line_phases; p++) begin
                wait_strobe();
                ct = expected_ctype(p, rows[r].badline);
                check_ctype($sformatf("ctype phase %0d", p), ct, slot.ctype);
                if (p < num_sprites * 4) begin
                    check_byte($sformatf("sprite_idx phase %0d", p), 8'(p / 4),
                               8'(slot.sprite_idx));
                end
                take_bits(12, bits);
                wr           = rows[r].wr_en && (int'(rows[r].wr_phase) == p);
                dbi          = char_word_t'(bits[11:0]);
                vic_write_db = wr;
                if (!wr) begin
                    model_capture(ct, p / 4, dbi, rows[r].idle, rows[r].dma);
                end
                @(negedge clk_dot4x);
                vic_write_db = 1'b0;
                check_outputs();
            end
        end
        assert_fails = int'(UUT.u_bus_access.u_assertions.fail_count);
        $display("all lines applied, %0d errors, %0d assertion failures",
                 errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/vic_pkg.sv
source/cycle_sequencer.sv
source/bus_access.sv
source/vic_fetch_top.sv
dv/vic_fetch_assertions.sv
dv/tb_vic_fetch.sv

// File: Bender.yml
package:
  name: vic_fetch

sources:
  - target: any(rtl, test)
    files:
      - source/vic_pkg.sv
      - source/cycle_sequencer.sv
      - source/bus_access.sv
      - source/vic_fetch_top.sv

  - target: test
    files:
      - dv/vic_fetch_assertions.sv
      - dv/tb_vic_fetch.sv
